/* verilog/histCfgPkg.sv */
package histCfgPkg;

    // array geometry
    // four pixels
    localparam int pixelBits = 2;
    // sixteen timing bins per pixel
    localparam int binBits = 4;

    // count width per bin
    localparam int countBits = 8;

    // memory address is {pixel, bin}
    localparam int addrBits = pixelBits + binBits;

    // saturation level of a bin count
    localparam logic [countBits-1:0] countMax = '1;

    // highest memory address, end of clear and scan walks
    localparam logic [addrBits-1:0] lastAddr = '1;

    // last bin index of one pixel
    localparam logic [binBits-1:0] lastBin = '1;

endpackage

/* verilog/histTypesPkg.sv */
package histTypesPkg;

    import histCfgPkg::*;

    // one photon event
    // pixel then bin, so the word doubles as a memory address
    typedef struct packed {
        logic [pixelBits-1:0] pixel;
        logic [binBits-1:0]   bin;
    } hitT;

    // write port request of the count memory
    typedef struct packed {
        logic                 en;
        logic [addrBits-1:0]  addr;
        logic [countBits-1:0] data;
    } ramWrT;

    // read port request, data comes back a cycle later
    typedef struct packed {
        logic                en;
        logic [addrBits-1:0] addr;
    } ramRdT;

    // one scanned bin toward the peak finder
    typedef struct packed {
        logic                 valid;
        // first and last bin of a pixel
        logic                 first;
        logic                 last;
        logic [pixelBits-1:0] pixel;
        logic [binBits-1:0]   bin;
        logic [countBits-1:0] count;
    } scanT;

    // per-pixel peak
    typedef struct packed {
        logic [pixelBits-1:0] pixel;
        logic [binBits-1:0]   bin;
        logic [countBits-1:0] count;
    } peakT;

endpackage

/* verilog/binRam.sv */
`timescale 1ns/1ps

module binRam #(
    parameter int addrBits = 6,
    parameter int dataBits = 8
) (
    input  logic                 clk,
    input  histTypesPkg::ramWrT  wr,
    input  histTypesPkg::ramRdT  rd,
    output logic [dataBits-1:0]  rdData
);

    // number of count words
    localparam int depth = 2 ** addrBits;

    // count storage, contents cleared by the controller
    logic [dataBits-1:0] mem [depth];

    // write port
    // takes effect at the clock edge
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port, registered
    // same-address write in the same cycle returns the old word
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdData <= mem[rd.addr];
        end
    end

    // a write never lands on an undefined address
    writeAddrKnown: assert property (
        @(posedge clk) wr.en |-> !$isunknown(wr.addr)
    ) else $error("binRam: write with unknown address");

    // a read request with unknown address leaves rdData undefined next cycle
    readAddrKnown: assert property (
        @(posedge clk) rd.en |=> !$isunknown(rdData) || $past($isunknown(rd.addr))
    ) else $error("binRam: read data unknown for a known address");

endmodule

/* verilog/histFsm.sv */
`timescale 1ns/1ps

module histFsm (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic                               hitValid,
    input  histTypesPkg::hitT                  hit,
    input  logic                               frameEnd,
    output logic                               ready,
    output histTypesPkg::ramRdT                rd,
    output histTypesPkg::ramWrT                wr,
    input  logic [histCfgPkg::countBits-1:0]   rdData,
    output histTypesPkg::scanT                 scan
);

    import histCfgPkg::*;
    import histTypesPkg::*;

    typedef enum logic [1:0] {
        sClear,
        sAccum,
        sDrain,
        sScan
    } stateT;

    stateT state;

    // shared walk counter for clear and scan
    logic [addrBits-1:0] addrCnt;

    // stage one of the read-modify-write
    logic                s1Valid;
    logic                s1Scan;
    logic [addrBits-1:0] s1Addr;

    // write issued in the previous cycle, bypass source
    ramWrT wrQ;

    logic                 bypass;
    logic [countBits-1:0] oldCount;
    logic [countBits-1:0] newCount;
    logic                 scanLastWr;

    // hits accepted only in accumulate
    assign ready = (state == sAccum);

    // final scan entry sits in stage one, read port goes quiet
    assign scanLastWr = s1Valid && s1Scan && (s1Addr == lastAddr);

    // state and walk counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= sClear;
            addrCnt <= '0;
        end else begin
            case (state)
                sClear: begin
                    // one zero write per cycle, wraps back to 0
                    addrCnt <= addrCnt + 1'b1;
                    if (addrCnt == lastAddr) begin
                        state <= sAccum;
                    end
                end
                sAccum: begin
                    if (frameEnd) begin
                        state <= sDrain;
                    end
                end
                sDrain: begin
                    // last hit write commits here
                    state <= sScan;
                end
                sScan: begin
                    if (rd.en) begin
                        addrCnt <= addrCnt + 1'b1;
                    end
                    // stay until the final zero write has gone out
                    if (scanLastWr) begin
                        state <= sAccum;
                    end
                end
                default: begin
                    state <= sClear;
                end
            endcase
        end
    end

    // read requests
    always_comb begin
        rd = '0;
        case (state)
            sAccum: begin
                rd.en   = hitValid;
                rd.addr = {hit.pixel, hit.bin};
            end
            sScan: begin
                rd.en   = !scanLastWr;
                rd.addr = addrCnt;
            end
            default: begin
                rd = '0;
            end
        endcase
    end

    // stage one control
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            s1Scan  <= 1'b0;
        end else begin
            s1Valid <= rd.en;
            s1Scan  <= (state == sScan);
        end
    end

    // stage one address, lines up with rdData
    always_ff @(posedge clk) begin
        s1Addr <= rd.addr;
    end

    // stage two
    // back-to-back hit on the same word reads stale data, take the in-flight count
    assign bypass   = wrQ.en && (wrQ.addr == s1Addr);
    assign oldCount = bypass ? wrQ.data : rdData;
    // saturating increment
    assign newCount = (oldCount == countMax) ? oldCount : oldCount + 1'b1;

    // write port
    always_comb begin
        wr.en   = 1'b0;
        wr.addr = s1Addr;
        wr.data = newCount;
        if (state == sClear) begin
            wr.en   = 1'b1;
            wr.addr = addrCnt;
            wr.data = '0;
        end else if (s1Valid) begin
            wr.en = 1'b1;
            // scan zeroes each bin right after reading it
            if (s1Scan) begin
                wr.data = '0;
            end
        end
    end

    // remember the last write for the bypass compare
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrQ <= '0;
        end else begin
            wrQ <= wr;
        end
    end

    // scan stream, one cycle after the read
    always_comb begin
        scan.valid = s1Valid && s1Scan;
        scan.pixel = s1Addr[addrBits-1:binBits];
        scan.bin   = s1Addr[binBits-1:0];
        scan.first = (s1Addr[binBits-1:0] == '0);
        scan.last  = (s1Addr[binBits-1:0] == lastBin);
        scan.count = rdData;
    end

    // inputs only while ready
    hitOnlyWhenReady: assert property (
        @(posedge clk) disable iff (!arstN) hitValid |-> ready
    ) else $error("histFsm: hit while not ready");

    frameEndOnlyWhenReady: assert property (
        @(posedge clk) disable iff (!arstN) frameEnd |-> ready
    ) else $error("histFsm: frameEnd while not ready");

endmodule

/* verilog/peakFinder.sv */
`timescale 1ns/1ps

module peakFinder (
    input  logic               clk,
    input  logic               arstN,
    input  histTypesPkg::scanT scan,
    output logic               peakValid,
    output histTypesPkg::peakT peak
);

    import histTypesPkg::*;

    // running maximum of the current pixel
    peakT best;
    // maximum including the entry now on scan
    peakT cand;
    logic higher;

    // strictly greater so ties keep the smaller bin
    assign higher = (scan.count > best.count);

    always_comb begin
        cand = best;
        // first bin of a pixel restarts the search
        if (scan.first || higher) begin
            cand = '{pixel: scan.pixel, bin: scan.bin, count: scan.count};
        end
    end

    // held maximum and result
    always_ff @(posedge clk) begin
        if (scan.valid) begin
            best <= cand;
            // result on the last bin of the pixel
            if (scan.last) begin
                peak <= cand;
            end
        end
    end

    // one pulse per pixel in the cycle after its last bin
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= scan.valid && scan.last;
        end
    end

    // all bins between first and last belong to one pixel
    pixelSteady: assert property (
        @(posedge clk) disable iff (!arstN)
        scan.valid && !scan.first |-> scan.pixel == best.pixel
    ) else $error("peakFinder: pixel changed inside a bin run");

endmodule

/* verilog/histTop.sv */
`timescale 1ns/1ps

module histTop (
    input  logic               clk,
    input  logic               arstN,
    input  logic               hitValid,
    input  histTypesPkg::hitT  hit,
    input  logic               frameEnd,
    output logic               ready,
    output logic               peakValid,
    output histTypesPkg::peakT peak
);

    import histCfgPkg::*;
    import histTypesPkg::*;

    // controller to memory
    ramRdT                rd;
    ramWrT                wr;
    logic [countBits-1:0] rdData;

    // controller to peak finder
    scanT scan;

    // clearing, accumulate and scan control
    histFsm fsm_i (
        .clk      (clk),
        .arstN    (arstN),
        .hitValid (hitValid),
        .hit      (hit),
        .frameEnd (frameEnd),
        .ready    (ready),
        .rd       (rd),
        .wr       (wr),
        .rdData   (rdData),
        .scan     (scan)
    );

    // count memory sized from the array geometry
    binRam #(
        .addrBits (addrBits),
        .dataBits (countBits)
    ) ram_i (
        .clk    (clk),
        .wr     (wr),
        .rd     (rd),
        .rdData (rdData)
    );

    // per-pixel peak search
    peakFinder peak_i (
        .clk       (clk),
        .arstN     (arstN),
        .scan      (scan),
        .peakValid (peakValid),
        .peak      (peak)
    );

endmodule

/* testbench/histTb.sv */
`timescale 1ns/1ps

module histTb;

    import histCfgPkg::*;
    import histTypesPkg::*;

    logic     clk = 1'b0;
    logic     arstN;
    logic     hitValid;
    hitT      hit;
    logic     frameEnd;
    logic     ready;
    logic     peakValid;
    peakT     peak;

    // random source
    logic [31:0] lfsr;
    // reference histogram indexed by {pixel, bin}
    logic [7:0]  model [64];
    // peaks of the last collected frame
    logic [3:0]  gotBin [4];
    logic [7:0]  gotCount [4];
    // high from frameEnd until all peaks are in
    logic        peaksOpen;

    histTop dut_i (
        .clk       (clk),
        .arstN     (arstN),
        .hitValid  (hitValid),
        .hit       (hit),
        .frameEnd  (frameEnd),
        .ready     (ready),
        .peakValid (peakValid),
        .peak      (peak)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1, "timeout");
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] nextBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic clearModel();
        for (int a = 0; a < 64; a++) begin
            model[6'(a)] = 8'd0;
        end
    endtask

    // one hit strobe with the model following under saturation
    task automatic sendHit(input logic [1:0] pixel, input logic [3:0] bin);
        @(posedge clk);
        hitValid <= 1'b1;
        hit      <= {pixel, bin};
        if (model[{pixel, bin}] != 8'd255) begin
            model[{pixel, bin}] = model[{pixel, bin}] + 8'd1;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        hitValid <= 1'b0;
    endtask

    task automatic waitReady();
        int n;
        n = 0;
        @(negedge clk);
        while (!ready) begin
            n++;
            if (n > 200) begin
                timeoutFail("ready did not rise");
            end
            @(negedge clk);
        end
    endtask

    task automatic waitPeak();
        int n;
        n = 0;
        @(negedge clk);
        while (!peakValid) begin
            n++;
            if (n > 100) begin
                timeoutFail("no peak result after frame end");
            end
            @(negedge clk);
        end
    endtask

    task automatic endFrame();
        @(posedge clk);
        hitValid  <= 1'b0;
        frameEnd  <= 1'b1;
        peaksOpen = 1'b1;
        @(posedge clk);
        frameEnd <= 1'b0;
    endtask

    // four peaks in pixel order against the model
    task automatic collectPeaks();
        logic [3:0] expBin;
        logic [7:0] expCount;
        for (int p = 0; p < 4; p++) begin
            expBin   = 4'd0;
            expCount = model[{2'(p), 4'd0}];
            // strictly greater keeps the smaller bin on a tie
            for (int b = 1; b < 16; b++) begin
                if (model[{2'(p), 4'(b)}] > expCount) begin
                    expBin   = 4'(b);
                    expCount = model[{2'(p), 4'(b)}];
                end
            end
            waitPeak();
            checkEq("peak.pixel", 32'(peak.pixel), 32'(p));
            checkEq("peak.bin", 32'(peak.bin), 32'(expBin));
            checkEq("peak.count", 32'(peak.count), 32'(expCount));
            gotBin[p]   = peak.bin;
            gotCount[p] = peak.count;
        end
        // pulse is over by the next falling edge
        @(negedge clk);
        peaksOpen = 1'b0;
    endtask

    task automatic randomFrame(input int hits);
        logic [31:0] r;
        clearModel();
        waitReady();
        for (int i = 0; i < hits; i++) begin
            // zero to three idle cycles before each hit
            r = nextBits(2);
            for (int g = 0; g < int'(r); g++) begin
                idle();
            end
            r = nextBits(6);
            sendHit(r[5:4], r[3:0]);
        end
        endFrame();
        collectPeaks();
    endtask

    // no results outside a scan and hits only while ready
    always @(negedge clk) begin
        if (arstN) begin
            if (!peaksOpen) begin
                checkEq("peakValid", 32'(peakValid), 32'd0);
            end
            if (hitValid) begin
                checkEq("ready", 32'(ready), 32'd1);
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] len;
        arstN     = 1'b0;
        hitValid  = 1'b0;
        hit       = '0;
        frameEnd  = 1'b0;
        peaksOpen = 1'b0;
        lfsr      = 32'h4378b564;
        clearModel();
        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        // memory clear after reset
        waitReady();

        // random hits on random cycles
        randomFrame(200);

        // same-address bursts back to back then A B A
        clearModel();
        waitReady();
        for (int k = 0; k < 12; k++) begin
            r   = nextBits(6);
            len = 32'd2 + nextBits(3);
            for (int j = 0; j < int'(len); j++) begin
                sendHit(r[5:4], r[3:0]);
            end
        end
        for (int k = 0; k < 4; k++) begin
            sendHit(2'd1, 4'd5);
            sendHit(2'd3, 4'd2);
            sendHit(2'd1, 4'd5);
        end
        endFrame();
        collectPeaks();

        // saturation on one bin
        clearModel();
        waitReady();
        for (int i = 0; i < 300; i++) begin
            sendHit(2'd2, 4'd7);
        end
        endFrame();
        collectPeaks();
        checkEq("saturated bin", 32'(gotBin[2]), 32'd7);
        checkEq("saturated count", 32'(gotCount[2]), 32'd255);

        // second random frame on memory cleared by the scan
        randomFrame(200);

        // empty pixel and ties
        clearModel();
        waitReady();
        for (int i = 0; i < 4; i++) begin
            sendHit(2'd0, 4'd9);
        end
        for (int i = 0; i < 4; i++) begin
            sendHit(2'd0, 4'd3);
        end
        for (int i = 0; i < 3; i++) begin
            sendHit(2'd2, 4'd15);
            idle();
            sendHit(2'd2, 4'd6);
        end
        sendHit(2'd3, 4'd10);
        sendHit(2'd3, 4'd5);
        endFrame();
        collectPeaks();
        checkEq("empty pixel bin", 32'(gotBin[1]), 32'd0);
        checkEq("empty pixel count", 32'(gotCount[1]), 32'd0);
        checkEq("tie bin pixel 0", 32'(gotBin[0]), 32'd3);
        checkEq("tie bin pixel 3", 32'(gotBin[3]), 32'd5);

        waitReady();
        $display("Test passed");
        $finish;
    end

endmodule

/* filelist.f */
verilog/histCfgPkg.sv
verilog/histTypesPkg.sv
verilog/binRam.sv
verilog/histFsm.sv
verilog/peakFinder.sv
verilog/histTop.sv
testbench/histTb.sv

/* run.sh */
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module histTb -o histSim

# the log decides the result, not the exit status
./obj_dir/histSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test passed" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation reported a failure"
    exit 1
fi
